// File: common/aq_settings.svh
`ifndef AQ_SETTINGS_SVH
`define AQ_SETTINGS_SVH

// Strobe synchronizer length
`define AQ_SYNC_DEPTH      3

// IO ports
`define AQ_IO_BANK_BASE    8'hF0   // $F0-$F3, low two bits pick the register
`define AQ_IO_CASSETTE     8'hFC
`define AQ_IO_PRINTER      8'hFE
`define AQ_IO_KEYBOARD     8'hFF

// Banking registers after reset
`define AQ_BANK0_RESET     8'hC0   // Read-only, overlay, page 0
`define AQ_BANK1_RESET     8'd33
`define AQ_BANK2_RESET     8'd34
`define AQ_BANK3_RESET     8'd19

// Sysram overlay at $3800-$3FFF, address bits 13..11
`define AQ_SYSRAM_WINDOW   3'd7

// Page ranges, 16-31 map to no chip
`define AQ_ROM_PAGE_LAST   6'd15
`define AQ_RAM_PAGE_FIRST  6'd32

`endif

// File: common/aq_pkg.sv
`default_nettype none

package aq_pkg;

    //////////////////////////////////////////////////////////////////////
    // Z80 side
    //////////////////////////////////////////////////////////////////////

    // CPU bus as the board sees it, strobes active low
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        rd_n;
        logic        wr_n;
        logic        mreq_n;
        logic        iorq_n;
    } cpu_bus_t;

    // One banking register, ro in bit 7
    typedef struct packed {
        logic       ro;      // Block writes to ROM/RAM
        logic       overlay; // Map sysram at $3800-$3FFF of the window
        logic [5:0] page;    // 16 KB page number
    } bank_reg_t;

    //////////////////////////////////////////////////////////////////////
    // Memory chip control
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic       rom_ce_n;
        logic       ram_ce_n;
        logic       ram_rom_we_n; // Shared by both chips
        logic [4:0] ba;           // Upper address bits of the chips
    } mem_sel_t;

endpackage

`default_nettype wire

// File: logic/bus_strobe.sv
`default_nettype none
`timescale 1ns/1ns

`include "aq_settings.svh"

module bus_strobe (
    input  wire                   sysclk,
    input  wire                   reset,
    input  wire aq_pkg::cpu_bus_t cpu,
    output logic [7:0]            wrdata,
    output logic                  bus_write
);

    logic [`AQ_SYNC_DEPTH-1:0] wr_n_sync;

    // Falling edge seen at the synchronizer output
    wire wr_fall = wr_n_sync[`AQ_SYNC_DEPTH-1 -: 2] == 2'b10;

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            wr_n_sync <= '1;   // Bus idle
            bus_write <= 1'b0;
        end else begin
            wr_n_sync <= {wr_n_sync[`AQ_SYNC_DEPTH-2:0], cpu.wr_n};
            bus_write <= wr_fall;
        end
    end

    // Data is stable long before the strobe arrives
    always_ff @(posedge sysclk) begin
        if (!cpu.wr_n)
            wrdata <= cpu.data;
    end

    // One strobe per write cycle
    a_write_single: assert property (@(posedge sysclk) disable iff (reset)
        bus_write |=> !bus_write);

endmodule

`default_nettype wire

// File: banking/bank_regs.sv
`default_nettype none
`timescale 1ns/1ns

`include "aq_settings.svh"

module bank_regs (
    input  wire                   sysclk,
    input  wire                   reset,
    input  wire aq_pkg::cpu_bus_t cpu,
    input  wire [7:0]             wrdata,
    input  wire                   bus_write,
    output aq_pkg::bank_reg_t     cur_bank,
    output logic [7:0]            bank_rddata
);

    import aq_pkg::*;

    bank_reg_t bank_r [4];   // IO $F0-$F3

    // Any of the four banking ports
    wire sel_io_bank = !cpu.iorq_n && {cpu.addr[7:2], 2'b00} == `AQ_IO_BANK_BASE;

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            bank_r[0] <= `AQ_BANK0_RESET;
            bank_r[1] <= `AQ_BANK1_RESET;
            bank_r[2] <= `AQ_BANK2_RESET;
            bank_r[3] <= `AQ_BANK3_RESET;
        end else if (sel_io_bank && bus_write) begin
            bank_r[cpu.addr[1:0]] <= wrdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Selection
    //////////////////////////////////////////////////////////////////////

    // Each 16 KB CPU window has its own register
    always_comb begin
        case (cpu.addr[15:14])
            2'd0:    cur_bank = bank_r[0];   // $0000-$3FFF
            2'd1:    cur_bank = bank_r[1];
            2'd2:    cur_bank = bank_r[2];
            default: cur_bank = bank_r[3];   // $C000-$FFFF
        endcase
    end

    // Readback picked by the IO port number
    always_comb begin
        case (cpu.addr[1:0])
            2'd0:    bank_rddata = bank_r[0];
            2'd1:    bank_rddata = bank_r[1];
            2'd2:    bank_rddata = bank_r[2];
            default: bank_rddata = bank_r[3];
        endcase
    end

endmodule

`default_nettype wire

// File: banking/mem_decode.sv
`default_nettype none
`timescale 1ns/1ns

`include "aq_settings.svh"

module mem_decode (
    input  wire aq_pkg::cpu_bus_t  cpu,
    input  wire aq_pkg::bank_reg_t cur_bank,
    output aq_pkg::mem_sel_t       mem
);

    // System RAM overlay, always in RAM page 32
    wire sel_sysram = !cpu.mreq_n && cur_bank.overlay &&
                      cpu.addr[13:11] == `AQ_SYSRAM_WINDOW;

    // No chip enable for a write into a read-only bank
    wire allow_sel = !cpu.mreq_n && !sel_sysram && (cpu.wr_n || !cur_bank.ro);

    wire sel_rom = allow_sel && cur_bank.page <= `AQ_ROM_PAGE_LAST;
    wire sel_ram = (allow_sel && cur_bank.page >= `AQ_RAM_PAGE_FIRST) || sel_sysram;

    // The overlay ignores ro, the banked chips do not
    wire wr_allow = sel_sysram || ((sel_rom || sel_ram) && !cur_bank.ro);

    always_comb begin
        mem.rom_ce_n     = !sel_rom;
        mem.ram_ce_n     = !sel_ram;
        mem.ram_rom_we_n = !(!cpu.wr_n && wr_allow);
        mem.ba           = sel_sysram ? 5'd0 : cur_bank.page[4:0];
    end

    // Page ranges and the overlay must keep the chips apart
    always_comb begin
        a_one_chip: assert (mem.rom_ce_n || mem.ram_ce_n)
            else $error("ROM and RAM enabled together");
    end

endmodule

`default_nettype wire

// File: logic/io_ports.sv
`default_nettype none
`timescale 1ns/1ns

`include "aq_settings.svh"

module io_ports (
    input  wire                   sysclk,
    input  wire                   reset,
    input  wire aq_pkg::cpu_bus_t cpu,
    input  wire [7:0]             wrdata,
    input  wire                   bus_write,
    input  wire [7:0]             bank_rddata,
    input  wire [63:0]            keys,
    input  wire                   cassette_in,
    input  wire                   printer_in,
    output logic [7:0]            rddata,
    output logic                  rddata_oe,
    output logic                  cassette_out,
    output logic                  printer_out
);

    logic [7:0] keyb_data;

    //////////////////////////////////////////////////////////////////////
    // IO decode
    //////////////////////////////////////////////////////////////////////
    wire sel_io_bank     = !cpu.iorq_n && {cpu.addr[7:2], 2'b00} == `AQ_IO_BANK_BASE;
    wire sel_io_cassette = !cpu.iorq_n && cpu.addr[7:0] == `AQ_IO_CASSETTE;
    wire sel_io_printer  = !cpu.iorq_n && cpu.addr[7:0] == `AQ_IO_PRINTER;
    wire sel_io_keyboard = !cpu.iorq_n && cpu.addr[7:0] == `AQ_IO_KEYBOARD;

    // Port answered by this board
    wire io_sel = sel_io_bank | sel_io_cassette | sel_io_printer | sel_io_keyboard;

    // Single-bit outputs
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            cassette_out <= 1'b0;
            printer_out  <= 1'b0;
        end else begin
            if (sel_io_cassette && bus_write) cassette_out <= wrdata[0];
            if (sel_io_printer  && bus_write) printer_out  <= wrdata[0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Keyboard matrix
    //////////////////////////////////////////////////////////////////////

    // A low address bit 8+k selects row k, selected rows are ANDed
    always_comb begin
        keyb_data = 8'hFF;
        for (int k = 0; k < 8; k++) begin
            if (!cpu.addr[8 + k])
                keyb_data &= keys[8*k +: 8];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read data
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        rddata = 8'h00;
        if (sel_io_bank)          rddata = bank_rddata;            // IO $F0-$F3
        else if (sel_io_cassette) rddata = {7'b0, cassette_in};    // IO $FC
        else if (sel_io_printer)  rddata = {7'b0, printer_in};     // IO $FE
        else if (sel_io_keyboard) rddata = keyb_data;              // IO $FF
    end

    assign rddata_oe = !cpu.rd_n && io_sel;

    // Never drive the data bus outside a read
    a_oe_on_read: assert property (@(posedge sysclk) disable iff (reset)
        rddata_oe |-> !cpu.rd_n);

endmodule

`default_nettype wire

// File: logic/aq_bus_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

module aq_bus_ctrl (
    input  wire                   sysclk,
    input  wire                   reset,
    input  wire aq_pkg::cpu_bus_t cpu,
    input  wire [63:0]            keys,      // Key matrix, row k in bits 8k+7..8k
    input  wire                   cassette_in,
    input  wire                   printer_in,
    output wire aq_pkg::mem_sel_t mem,
    output wire [7:0]             rddata,
    output wire                   rddata_oe,
    output wire                   cassette_out,
    output wire                   printer_out
);

    import aq_pkg::*;

    wire [7:0] wrdata;
    wire       bus_write;
    wire [7:0] bank_rddata;
    bank_reg_t cur_bank;     // Register of the current 16 KB window

    //////////////////////////////////////////////////////////////////////
    // Bus timing
    //////////////////////////////////////////////////////////////////////
    bus_strobe u_bus_strobe (
        .sysclk    (sysclk),
        .reset     (reset),
        .cpu       (cpu),
        .wrdata    (wrdata),
        .bus_write (bus_write)
    );

    //////////////////////////////////////////////////////////////////////
    // Banking and memory decode
    //////////////////////////////////////////////////////////////////////
    bank_regs u_bank_regs (
        .sysclk      (sysclk),
        .reset       (reset),
        .cpu         (cpu),
        .wrdata      (wrdata),
        .bus_write   (bus_write),
        .cur_bank    (cur_bank),
        .bank_rddata (bank_rddata)
    );

    mem_decode u_mem_decode (
        .cpu      (cpu),
        .cur_bank (cur_bank),
        .mem      (mem)
    );

    //////////////////////////////////////////////////////////////////////
    // IO ports
    //////////////////////////////////////////////////////////////////////
    io_ports u_io_ports (
        .sysclk       (sysclk),
        .reset        (reset),
        .cpu          (cpu),
        .wrdata       (wrdata),
        .bus_write    (bus_write),
        .bank_rddata  (bank_rddata),
        .keys         (keys),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .rddata       (rddata),
        .rddata_oe    (rddata_oe),
        .cassette_out (cassette_out),
        .printer_out  (printer_out)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`default_nettype none
`timescale 1ns/1ns

module tb_clock (
    output logic sysclk,
    output logic reset
);

    localparam int half_period  = 10;   // 20 ns clock
    localparam int reset_cycles = 16;

    initial begin
        sysclk = 1'b0;
        forever #half_period sysclk = ~sysclk;
    end

    // Reset released on a rising edge after the hold time
    initial begin
        int count;
        reset = 1'b1;
        count = 0;
        while (count < reset_cycles) begin
            @(posedge sysclk);
            count++;
        end
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/tb_aq_bus_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

module tb_aq_bus_ctrl;

    import aq_pkg::*;

    localparam string cases_file    = "verification/aq_bus_cases.txt";
    localparam int    settle_cycles = 2;    // Combinational outputs sampled here
    localparam int    write_hold    = 5;    // Strobe plus register update
    localparam int    idle_cycles   = 3;
    localparam int    reset_timeout = 100;

    localparam cpu_bus_t idle_bus = '{addr: 16'h0000, data: 8'h00, rd_n: 1'b1,
                                      wr_n: 1'b1, mreq_n: 1'b1, iorq_n: 1'b1};

    wire         sysclk;
    wire         reset;
    cpu_bus_t    cpu;
    logic [63:0] keys;
    logic        cassette_in;
    logic        printer_in;
    mem_sel_t    mem;
    wire [7:0]   rddata;
    wire         rddata_oe;
    wire         cassette_out;
    wire         printer_out;

    // Current line of the cases file
    byte         c_op;
    logic [15:0] c_addr;
    logic [7:0]  c_data;
    logic [63:0] c_keys;
    logic        c_cin;
    logic        c_pin;
    logic [7:0]  exp_rd;
    logic        exp_oe;
    logic [7:0]  exp_mem;
    logic        exp_cas;
    logic        exp_prn;

    int errors = 0;

    tb_clock u_clock (
        .sysclk (sysclk),
        .reset  (reset)
    );

    aq_bus_ctrl dut (
        .sysclk       (sysclk),
        .reset        (reset),
        .cpu          (cpu),
        .keys         (keys),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .mem          (mem),
        .rddata       (rddata),
        .rddata_oe    (rddata_oe),
        .cassette_out (cassette_out),
        .printer_out  (printer_out)
    );

    //////////////////////////////////////////////////////////////////////
    // Waits and checks
    //////////////////////////////////////////////////////////////////////
    task automatic wait_cycles(input int n);
        int count;
        count = 0;
        while (count < n) begin
            @(posedge sysclk);
            count++;
        end
    endtask

    // Reset is only looked at on clock edges, after the generator has started
    task automatic wait_reset_release(output logic released);
        int count;
        count = 0;
        do begin
            @(posedge sysclk);
            count++;
        end while (reset !== 1'b0 && count < reset_timeout);
        released = (reset === 1'b0);
    endtask

    task automatic check_rddata(input logic [7:0] got, input logic got_oe,
                                input logic [7:0] exp, input logic exp_en);
        if (got !== exp || got_oe !== exp_en) begin
            $display("MISMATCH at %0t: rddata %h oe %b, expected %h oe %b",
                     $time, got, got_oe, exp, exp_en);
            errors++;
        end
    endtask

    task automatic check_mem(input mem_sel_t got, input mem_sel_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: mem rom_ce_n %b ram_ce_n %b we_n %b ba %h, expected %h",
                     $time, got.rom_ce_n, got.ram_ce_n, got.ram_rom_we_n, got.ba, exp);
            errors++;
        end
    endtask

    task automatic check_pin(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // One bus cycle as given by the current line
    task automatic run_case();
        logic is_io;
        logic is_write;
        is_io    = (c_op == "I" || c_op == "i");
        is_write = (c_op == "I" || c_op == "M");
        wait_cycles(1);
        cpu.addr    <= c_addr;
        cpu.data    <= c_data;
        cpu.rd_n    <= is_write;
        cpu.wr_n    <= !is_write;
        cpu.mreq_n  <= is_io;
        cpu.iorq_n  <= !is_io;
        keys        <= c_keys;
        cassette_in <= c_cin;
        printer_in  <= c_pin;
        wait_cycles(settle_cycles);
        if (!is_write) check_rddata(rddata, rddata_oe, exp_rd, exp_oe);
        if (!is_io) check_mem(mem, mem_sel_t'(exp_mem));
        if (is_write) wait_cycles(write_hold - settle_cycles);   // Keep addr and data stable
        wait_cycles(1);
        cpu <= idle_bus;
        wait_cycles(idle_cycles);
        check_pin("cassette_out", cassette_out, exp_cas);
        check_pin("printer_out", printer_out, exp_prn);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin : main
        int    fd;
        int    got;
        int    n_cases;
        int    n_failed;
        int    errors_before;
        logic  released;
        string line;
        cpu         <= idle_bus;
        keys        <= '1;
        cassette_in <= 1'b0;
        printer_in  <= 1'b0;
        n_cases  = 0;
        n_failed = 0;
        fd = $fopen(cases_file, "r");
        if (fd == 0) begin
            $display("Could not open the cases file %s", cases_file);
            errors++;
        end else begin
            wait_reset_release(released);
            if (!released) begin
                $display("Reset still active after %0d cycles", reset_timeout);
                errors++;
            end else begin
                while (!$feof(fd)) begin
                    got = $fgets(line, fd);
                    if (got > 1 && line[0] != "#") begin
                        got = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h", c_op, c_addr,
                                      c_data, c_keys, c_cin, c_pin, exp_rd, exp_oe, exp_mem,
                                      exp_cas, exp_prn);
                        if (got != 11) begin
                            $display("Badly formed line in the cases file: %s", line);
                            errors++;
                        end else begin
                            errors_before = errors;
                            run_case();
                            n_cases++;
                            if (errors != errors_before) n_failed++;
                            $display("case %0d %c %h %s", n_cases, c_op, c_addr,
                                     errors == errors_before ? "ok" : "FAIL");
                        end
                    end
                end
            end
            $fclose(fd);
        end
        $display("%0d cases run, %0d failed, %0d errors", n_cases, n_failed, errors);
        if (errors == 0 && n_cases > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/aq_bus_cases.txt
# op: I io write, i io read, M mem write, m mem read; all values hex
# op addr data keys cas_in prn_in rddata rddata_oe mem cas_out prn_out (rddata on reads, mem on M/m)
i 00F0 00 0000000000000000 0 0 C0 1 00 0 0
i 00F1 00 0000000000000000 0 0 21 1 00 0 0
i 00F2 00 0000000000000000 0 0 22 1 00 0 0
i 00F3 00 0000000000000000 0 0 13 1 00 0 0
I 00F2 28 0000000000000000 0 0 00 0 00 0 0
i 00F2 00 0000000000000000 0 0 28 1 00 0 0
m 8000 00 0000000000000000 0 0 00 0 A8 0 0
I 00F1 05 0000000000000000 0 0 00 0 00 0 0
m 4000 00 0000000000000000 0 0 00 0 65 0 0
M 4123 5A 0000000000000000 0 0 00 0 45 0 0
M 8010 33 0000000000000000 0 0 00 0 88 0 0
I 00F3 A2 0000000000000000 0 0 00 0 00 0 0
M C000 11 0000000000000000 0 0 00 0 E2 0 0
m C000 00 0000000000000000 0 0 00 0 A2 0 0
I 00F1 12 0000000000000000 0 0 00 0 00 0 0
m 4000 00 0000000000000000 0 0 00 0 F2 0 0
m 3900 00 0000000000000000 0 0 00 0 A0 0 0
M 3900 77 0000000000000000 0 0 00 0 80 0 0
M 3000 44 0000000000000000 0 0 00 0 E0 0 0
m 3000 00 0000000000000000 0 0 00 0 60 0 0
i FEFF 00 FFFFFFEFFFFFFF7E 0 0 7E 1 00 0 0
i 00FF 00 FFFFFFEFFFFFFF7E 0 0 6E 1 00 0 0
i FFFF 00 FFFFFFEFFFFFFF7E 0 0 FF 1 00 0 0
i EFFF 00 FFFFFFEFFFFFFF7E 0 0 EF 1 00 0 0
I 00FC 01 0000000000000000 0 0 00 0 00 1 0
I 00FE 01 0000000000000000 0 0 00 0 00 1 1
i 00FC 00 0000000000000000 1 0 01 1 00 1 1
i 00FE 00 0000000000000000 0 1 01 1 00 1 1
i 0080 00 0000000000000000 1 1 00 0 00 1 1
I 00FC 00 0000000000000000 0 0 00 0 00 0 1

// File: aq_bus_ctrl.f
+incdir+common
common/aq_pkg.sv
logic/bus_strobe.sv
banking/bank_regs.sv
banking/mem_decode.sv
logic/io_ports.sv
logic/aq_bus_ctrl.sv
verification/tb_clock.sv
verification/tb_aq_bus_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_aq_bus_ctrl
FILELIST  ?= aq_bus_ctrl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_MSG  ?= all tests passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) common/aq_settings.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
